// ==== router_pkg.sv ====
////////////////////////////////////////
// Router shared types
////////////////////////////////////////

`default_nettype none

package router_pkg;

    localparam int port_width   = 4;   // 16 table entries
    localparam int length_width = 16;  // byte length field

    // sampled from the first word of a packet
    typedef struct packed {
        logic [port_width-1:0] ingress_port;
    } ingress_metadata_t;

    // carried out with every egress word
    typedef struct packed {
        logic [port_width-1:0]   ingress_port;
        logic [port_width-1:0]   egress_port;
        logic [length_width-1:0] byte_length;
    } router_metadata_t;

    // builder -> arbiter
    typedef struct packed {
        logic [port_width-1:0]   ingress_port;
        logic [length_width-1:0] byte_length;
    } lookup_req_t;

    // arbiter grant -> table
    typedef struct packed {
        logic                  write;  // 1 = write, 0 = read
        logic [port_width-1:0] addr;   // table index
        logic [port_width-1:0] wdata;  // new egress port
    } table_access_t;

endpackage

`default_nettype wire

// ==== stream_fifo.sv ====
////////////////////////////////////////
// Typed synchronous FIFO
////////////////////////////////////////

`default_nettype none

module stream_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  depth  = 4
) (
    input  var logic  packet_data_in,
    input  var logic  rst,
    input  var logic  push,
    input  var item_t push_item,
    output logic      full,
    input  var logic  pop,
    output item_t     pop_item,
    output logic      empty
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_width-1:0] last_idx = ptr_width'(depth - 1);

    item_t                mem [depth];  // storage
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;        // occupancy
    logic                 do_push;
    logic                 do_pop;

    assign do_push  = push & ~full;
    assign do_pop   = pop & ~empty;
    assign full     = (count == (ptr_width + 1)'(depth));
    assign empty    = (count == '0);
    assign pop_item = mem[rd_ptr];  // fall-through head

    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;  // wrap at depth
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or both
            endcase
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

endmodule

`default_nettype wire

// ==== metadata_builder.sv ====
////////////////////////////////////////
// Packet length and lookup request
////////////////////////////////////////

`default_nettype none

module metadata_builder #(
    parameter int data_bytes = 8
) (
    input  var logic                          packet_data_in,
    input  var logic                          rst,
    input  var logic                          in_valid,
    input  var logic                          in_ready,   // fire qualifier
    input  var logic [data_bytes-1:0]         in_keep,
    input  var logic                          in_last,
    input  var router_pkg::ingress_metadata_t in_meta,
    output logic                              req_valid,
    output router_pkg::lookup_req_t           req,
    input  var logic                          req_grant,
    output logic                              req_busy
);

    localparam logic [router_pkg::length_width-1:0] bytes_per_word =
        router_pkg::length_width'(data_bytes);

    logic                                fire;        // word accepted
    logic [router_pkg::length_width-1:0] word_cnt;    // full words so far
    logic [router_pkg::length_width-1:0] keep_bytes;  // popcount of keep
    logic [router_pkg::port_width-1:0]   port_q;      // first word port
    logic [router_pkg::port_width-1:0]   port_now;

    assign fire     = in_valid & in_ready;
    assign req_busy = req_valid;  // slot taken until granted
    // single word packets take the port straight from the bus
    assign port_now = (word_cnt == '0) ? in_meta.ingress_port : port_q;

    always_comb begin
        keep_bytes = '0;
        for (int i = 0; i < data_bytes; i++) begin
            keep_bytes = keep_bytes + {{(router_pkg::length_width-1){1'b0}}, in_keep[i]};
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            word_cnt  <= '0;
            req_valid <= 1'b0;
        end else begin
            if (fire) begin
                word_cnt <= in_last ? '0 : word_cnt + 1'b1;  // clear on last
            end
            if (fire && in_last) begin
                req_valid <= 1'b1;
            end else if (req_grant) begin
                req_valid <= 1'b0;  // handed to arbiter
            end
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (fire && word_cnt == '0) begin
            port_q <= in_meta.ingress_port;
        end
        if (fire && in_last) begin
            req.ingress_port <= port_now;
            req.byte_length  <= word_cnt * bytes_per_word + keep_bytes;
        end
    end

endmodule

`default_nettype wire

// ==== port_table_arbiter.sv ====
////////////////////////////////////////
// Port table arbiter
////////////////////////////////////////

`default_nettype none

module port_table_arbiter (
    input  var logic                                packet_data_in,
    input  var logic                                rst,
    input  var logic                                lookup_valid,
    input  var logic [router_pkg::port_width-1:0]   lookup_port,
    output logic                                    lookup_grant,
    input  var logic                                ctl_write,
    input  var logic                                ctl_read,
    input  var logic [router_pkg::port_width-1:0]   ctl_addr,
    input  var logic [router_pkg::port_width-1:0]   ctl_wdata,
    output logic                                    ctl_busy,
    output logic                                    access_valid,
    output router_pkg::table_access_t               access,
    output logic                                    access_is_ctl
);

    logic                              ctl_pend;    // strobe waiting
    logic                              pend_write;
    logic [router_pkg::port_width-1:0] pend_addr;
    logic [router_pkg::port_width-1:0] pend_wdata;
    logic                              last_ctl;    // last grant went to ctl
    logic                              grant_ctl;

    // ctl wins unless it had the previous grant
    assign grant_ctl     = ctl_pend & (~lookup_valid | ~last_ctl);
    assign lookup_grant  = lookup_valid & ~grant_ctl;
    assign access_valid  = grant_ctl | lookup_grant;
    assign access_is_ctl = grant_ctl;
    assign ctl_busy      = ctl_pend;

    always_comb begin
        access.write = grant_ctl & pend_write;  // lookups only read
        access.addr  = grant_ctl ? pend_addr : lookup_port;
        access.wdata = pend_wdata;
    end

    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            ctl_pend <= 1'b0;
            last_ctl <= 1'b0;
        end else begin
            if (ctl_write || ctl_read) begin
                ctl_pend <= 1'b1;
            end else if (grant_ctl) begin
                ctl_pend <= 1'b0;  // write done here
            end
            if (access_valid) begin
                last_ctl <= grant_ctl;
            end
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (ctl_write || ctl_read) begin
            pend_write <= ctl_write;
            pend_addr  <= ctl_addr;
            pend_wdata <= ctl_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== port_table.sv ====
////////////////////////////////////////
// Egress port table
////////////////////////////////////////

`default_nettype none

module port_table (
    input  var logic                              packet_data_in,
    input  var logic                              rst,
    input  var logic                              access_valid,
    input  var router_pkg::table_access_t         access,
    input  var logic                              access_is_ctl,
    output logic                                  lookup_rvalid,
    output logic                                  ctl_rvalid,
    output logic [router_pkg::port_width-1:0]     rdata
);

    localparam int entries = 2 ** router_pkg::port_width;

    logic [router_pkg::port_width-1:0] table_q [entries];  // egress per ingress
    logic                              rd_en;

    assign rd_en = access_valid & ~access.write;

    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                table_q[i] <= i[router_pkg::port_width-1:0];  // echo mapping
            end
            lookup_rvalid <= 1'b0;
            ctl_rvalid    <= 1'b0;
        end else begin
            if (access_valid && access.write) begin
                table_q[access.addr] <= access.wdata;
            end
            lookup_rvalid <= rd_en & ~access_is_ctl;  // tag by requester
            ctl_rvalid    <= rd_en & access_is_ctl;
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (rd_en) begin
            rdata <= table_q[access.addr];
        end
    end

endmodule

`default_nettype wire

// ==== egress_stage.sv ====
////////////////////////////////////////
// Egress word and result join
////////////////////////////////////////

`default_nettype none

module egress_stage #(
    parameter int  data_bytes = 8,
    parameter type word_t     = logic [data_bytes*9-1:0]
) (
    input  var logic                              packet_data_in,
    input  var logic                              rst,
    input  var logic                              word_empty,
    input  var word_t                             word_item,
    output logic                                  word_pop,
    input  var logic                              last_flag,
    input  var logic                              result_empty,
    input  var router_pkg::router_metadata_t      result,
    output logic                                  result_pop,
    output logic                                  out_valid,
    input  var logic                              out_ready,
    output logic [data_bytes*8-1:0]               out_data,
    output logic [data_bytes-1:0]                 out_keep,
    output logic                                  out_last,
    output router_pkg::router_metadata_t          out_meta
);

    logic load;  // move head word into output register

    // a word only leaves once its packet's result is queued
    assign load       = ~word_empty & ~result_empty & (~out_valid | out_ready);
    assign word_pop   = load;
    assign result_pop = load & last_flag;  // result retires with packet

    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;  // drained
            end
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (load) begin
            {out_data, out_keep} <= word_item;  // held stable under stall
            out_last             <= last_flag;
            out_meta             <= result;
        end
    end

endmodule

`default_nettype wire

// ==== p4_router_echo_top.sv ====
////////////////////////////////////////
// Router pipeline top
////////////////////////////////////////

`default_nettype none

module p4_router_echo_top #(
    parameter int data_bytes   = 8,
    parameter int fifo_depth   = 32,
    parameter int result_depth = 4
) (
    input  var logic                              packet_data_in,
    input  var logic                              rst,
    // input stream
    input  var logic                              in_valid,
    output logic                                  in_ready,
    input  var logic [data_bytes*8-1:0]           in_data,
    input  var logic [data_bytes-1:0]             in_keep,
    input  var logic                              in_last,
    input  var router_pkg::ingress_metadata_t     in_meta,
    // output stream
    output logic                                  out_valid,
    input  var logic                              out_ready,
    output logic [data_bytes*8-1:0]               out_data,
    output logic [data_bytes-1:0]                 out_keep,
    output logic                                  out_last,
    output router_pkg::router_metadata_t          out_meta,
    // control port
    input  var logic                              ctl_write,
    input  var logic                              ctl_read,
    input  var logic [router_pkg::port_width-1:0] ctl_addr,
    input  var logic [router_pkg::port_width-1:0] ctl_wdata,
    output logic                                  ctl_busy,
    output logic                                  ctl_rvalid,
    output logic [router_pkg::port_width-1:0]     ctl_rdata
);

    typedef struct packed {
        logic [data_bytes*8-1:0] data;
        logic [data_bytes-1:0]   keep;
    } stream_word_t;

    typedef struct packed {
        stream_word_t word;
        logic         last;
    } fifo_item_t;

    ////////////////////////////////////////
    // signals

    fifo_item_t                        in_item;
    fifo_item_t                        head_item;
    logic                              data_full;
    logic                              data_empty;
    logic                              data_pop;
    logic                              req_valid;
    logic                              req_busy;
    logic                              lookup_valid;
    logic                              lookup_grant;
    router_pkg::lookup_req_t           req;
    router_pkg::lookup_req_t           pend_req;    // granted, awaiting read
    logic                              access_valid;
    logic                              access_is_ctl;
    router_pkg::table_access_t         access;
    logic                              lookup_rvalid;
    logic [router_pkg::port_width-1:0] rdata;
    router_pkg::router_metadata_t      result_in;
    router_pkg::router_metadata_t      result_head;
    logic                              result_full;
    logic                              result_empty;
    logic                              result_pop;

    assign in_ready       = ~data_full & ~req_busy;  // one lookup in flight
    assign in_item.word   = '{data: in_data, keep: in_keep};
    assign in_item.last   = in_last;
    assign lookup_valid   = req_valid & ~result_full;  // no result overflow
    assign ctl_rdata      = rdata;

    assign result_in.ingress_port = pend_req.ingress_port;
    assign result_in.egress_port  = rdata;
    assign result_in.byte_length  = pend_req.byte_length;

    always_ff @(posedge packet_data_in) begin
        if (lookup_grant) begin
            pend_req <= req;
        end
    end

    ////////////////////////////////////////
    // ingress side

    stream_fifo #(.item_t(fifo_item_t), .depth(fifo_depth)) data_fifo_inst (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .push           (in_valid & in_ready),
        .push_item      (in_item),
        .full           (data_full),
        .pop            (data_pop),
        .pop_item       (head_item),
        .empty          (data_empty)
    );

    metadata_builder #(.data_bytes(data_bytes)) metadata_builder_inst (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_keep        (in_keep),
        .in_last        (in_last),
        .in_meta        (in_meta),
        .req_valid      (req_valid),
        .req            (req),
        .req_grant      (lookup_grant),
        .req_busy       (req_busy)
    );

    ////////////////////////////////////////
    // shared port table

    port_table_arbiter port_table_arbiter_inst (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .lookup_valid   (lookup_valid),
        .lookup_port    (req.ingress_port),
        .lookup_grant   (lookup_grant),
        .ctl_write      (ctl_write),
        .ctl_read       (ctl_read),
        .ctl_addr       (ctl_addr),
        .ctl_wdata      (ctl_wdata),
        .ctl_busy       (ctl_busy),
        .access_valid   (access_valid),
        .access         (access),
        .access_is_ctl  (access_is_ctl)
    );

    port_table port_table_inst (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .access_valid   (access_valid),
        .access         (access),
        .access_is_ctl  (access_is_ctl),
        .lookup_rvalid  (lookup_rvalid),
        .ctl_rvalid     (ctl_rvalid),
        .rdata          (rdata)
    );

    ////////////////////////////////////////
    // egress side

    stream_fifo #(
        .item_t (router_pkg::router_metadata_t),
        .depth  (result_depth)
    ) result_fifo_inst (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .push           (lookup_rvalid),  // lookup done
        .push_item      (result_in),
        .full           (result_full),
        .pop            (result_pop),
        .pop_item       (result_head),
        .empty          (result_empty)
    );

    egress_stage #(.data_bytes(data_bytes), .word_t(stream_word_t)) egress_stage_inst (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .word_empty     (data_empty),
        .word_item      (head_item.word),
        .word_pop       (data_pop),
        .last_flag      (head_item.last),
        .result_empty   (result_empty),
        .result         (result_head),
        .result_pop     (result_pop),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_data       (out_data),
        .out_keep       (out_keep),
        .out_last       (out_last),
        .out_meta       (out_meta)
    );

endmodule

`default_nettype wire

// ==== tb_router.sv ====
////////////////////////////////////////
// Router pipeline testbench
////////////////////////////////////////

`default_nettype none

module tb_router;

    localparam int data_bytes    = 8;
    localparam int timeout_limit = 4000;  // all tests with margin

    typedef struct packed {
        logic [data_bytes*8-1:0]      data;
        logic [data_bytes-1:0]        keep;
        logic                         last;
        router_pkg::router_metadata_t meta;
    } out_word_t;

    logic                              packet_data_in;
    logic                              rst;
    logic                              in_valid;
    logic                              in_ready;
    logic [data_bytes*8-1:0]           in_data;
    logic [data_bytes-1:0]             in_keep;
    logic                              in_last;
    router_pkg::ingress_metadata_t     in_meta;
    logic                              out_valid;
    logic                              out_ready;
    logic [data_bytes*8-1:0]           out_data;
    logic [data_bytes-1:0]             out_keep;
    logic                              out_last;
    router_pkg::router_metadata_t      out_meta;
    logic                              ctl_write;
    logic                              ctl_read;
    logic [router_pkg::port_width-1:0] ctl_addr;
    logic [router_pkg::port_width-1:0] ctl_wdata;
    logic                              ctl_busy;
    logic                              ctl_rvalid;
    logic [router_pkg::port_width-1:0] ctl_rdata;

    integer    seed;
    int        cycle_count  = 0;
    int        error_count  = 0;
    int        test_count   = 0;
    int        failed_tests = 0;
    int        errors_before;                              // errors at test start
    string     test_name    = "none";
    logic      ready_random;                               // back-pressure on
    logic      stall_pattern [256];
    out_word_t expected_q [$];                             // words owed by the DUT
    logic [router_pkg::port_width-1:0] model_table [16];  // expected port map

    p4_router_echo_top #(
        .data_bytes   (data_bytes),
        .fifo_depth   (32),
        .result_depth (4)
    ) p4_router_echo_top_inst (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_data        (in_data),
        .in_keep        (in_keep),
        .in_last        (in_last),
        .in_meta        (in_meta),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_data       (out_data),
        .out_keep       (out_keep),
        .out_last       (out_last),
        .out_meta       (out_meta),
        .ctl_write      (ctl_write),
        .ctl_read       (ctl_read),
        .ctl_addr       (ctl_addr),
        .ctl_wdata      (ctl_wdata),
        .ctl_busy       (ctl_busy),
        .ctl_rvalid     (ctl_rvalid),
        .ctl_rdata      (ctl_rdata)
    );

    initial begin
        packet_data_in = 1'b0;
        forever #2 packet_data_in = ~packet_data_in;  // period 4
    end

    always @(posedge packet_data_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: run still busy after %0d cycles", timeout_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////
    // checking helpers

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        error_count = error_count + 1;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = error_count;
    endtask

    task automatic end_test();
        test_count = test_count + 1;
        if (error_count == errors_before) begin
            $display("test %s: passed", test_name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %s: failed with %0d errors", test_name, error_count - errors_before);
        end
    endtask

    // drives out_ready and scores every transfer
    initial begin
        out_word_t  held;
        out_word_t  got;
        out_word_t  want;
        logic       stalled;
        logic [7:0] pattern_idx;
        stalled     = 1'b0;
        pattern_idx = 8'd0;
        out_ready   = 1'b1;
        forever begin
            @(negedge packet_data_in);
            got = '{data: out_data, keep: out_keep, last: out_last, meta: out_meta};
            if (stalled && (!out_valid || got !== held)) begin
                report_error("output word changed while stalled");
            end
            out_ready   = ready_random ? stall_pattern[pattern_idx] : 1'b1;
            pattern_idx = pattern_idx + 8'd1;
            stalled     = out_valid & ~out_ready;
            held        = got;
            if (out_valid && out_ready) begin  // transfer on next rising edge
                if (expected_q.size() == 0) begin
                    report_error("output word arrived with no packet owed");
                end else begin
                    want = expected_q.pop_front();
                    check_value("out_data", want.data, got.data);
                    check_value("out_keep", 64'(want.keep), 64'(got.keep));
                    check_value("out_last", 64'(want.last), 64'(got.last));
                    check_value("out_meta", 64'(want.meta), 64'(got.meta));
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus tasks entered on a falling edge

    task automatic send_packet(input logic [3:0] port, input int words,
                               input logic [7:0] last_keep);
        out_word_t want;
        for (int w = 0; w < words; w++) begin
            in_valid             = 1'b1;
            in_data              = {$random(seed), $random(seed)};
            in_keep              = (w == words - 1) ? last_keep : 8'hff;
            in_last              = (w == words - 1);
            in_meta.ingress_port = (w == 0) ? port : ~port;  // later words ignored
            want.data              = in_data;
            want.keep              = in_keep;
            want.last              = in_last;
            want.meta.ingress_port = port;
            want.meta.egress_port  = model_table[port];
            want.meta.byte_length  = 16'((words - 1) * data_bytes) + 16'($countones(last_keep));
            expected_q.push_back(want);
            while (!in_ready) @(negedge packet_data_in);  // hold until accepted
            @(negedge packet_data_in);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) @(negedge packet_data_in);
        repeat (2) @(negedge packet_data_in);
        if (out_valid) begin
            report_error("output still valid after the last owed word");
        end
    endtask

    task automatic write_entry(input logic [3:0] addr, input logic [3:0] data);
        while (ctl_busy) @(negedge packet_data_in);
        ctl_write = 1'b1;
        ctl_addr  = addr;
        ctl_wdata = data;
        @(negedge packet_data_in);
        ctl_write = 1'b0;
        while (ctl_busy) @(negedge packet_data_in);  // done at grant
        model_table[addr] = data;
    endtask

    task automatic read_entry(input logic [3:0] addr, output logic [3:0] data);
        while (ctl_busy) @(negedge packet_data_in);
        ctl_read = 1'b1;
        ctl_addr = addr;
        @(negedge packet_data_in);
        ctl_read = 1'b0;
        while (!ctl_rvalid) @(negedge packet_data_in);  // waits out arbitration
        data = ctl_rdata;
    endtask

    ////////////////////////////////////////
    // directed tests

    task automatic verify_reset_state();
        begin_test("reset_state");
        check_value("out_valid", 64'd0, 64'(out_valid));
        check_value("ctl_busy", 64'd0, 64'(ctl_busy));
        check_value("ctl_rvalid", 64'd0, 64'(ctl_rvalid));
        check_value("in_ready", 64'd1, 64'(in_ready));
        end_test();
    endtask

    task automatic route_default_echo();
        begin_test("echo_default");
        send_packet(4'd5, 3, 8'h3f);  // 2*8 + 6 bytes, egress 5
        wait_drain();
        end_test();
    endtask

    task automatic remap_through_control();
        logic [3:0] value;
        begin_test("control");
        write_entry(4'd5, 4'd9);
        read_entry(4'd5, value);
        check_value("entry 5 readback", 64'd9, 64'(value));
        send_packet(4'd5, 2, 8'h01);
        wait_drain();
        end_test();
    endtask

    task automatic stall_output_randomly();
        begin_test("back_pressure");
        ready_random = 1'b1;
        send_packet(4'd3, 4, 8'hff);
        send_packet(4'd7, 1, 8'h0f);
        send_packet(4'd5, 5, 8'h03);
        send_packet(4'd12, 2, 8'h7f);
        wait_drain();
        ready_random = 1'b0;
        end_test();
    endtask

    task automatic contend_for_table();
        logic [3:0] value;
        begin_test("contention");
        fork
            for (int p = 0; p < 6; p++) begin
                send_packet(4'(p % 4 + 1), p % 3 + 1, 8'h0f);  // ports 1 to 4
            end
            for (int a = 12; a < 16; a++) begin
                write_entry(4'(a), 4'(a) ^ 4'h6);  // entries no packet uses
            end
        join
        wait_drain();
        for (int a = 0; a < 16; a++) begin
            read_entry(4'(a), value);
            check_value($sformatf("entry %0d readback", a), 64'(model_table[4'(a)]),
                        64'(value));
        end
        end_test();
    endtask

    initial begin
        seed         = 65405;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        in_keep      = '0;
        in_last      = 1'b0;
        in_meta      = '0;
        ctl_write    = 1'b0;
        ctl_read     = 1'b0;
        ctl_addr     = '0;
        ctl_wdata    = '0;
        ready_random = 1'b0;
        for (int i = 0; i < 256; i++) begin
            stall_pattern[i] = 1'($random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            model_table[i] = 4'(i);  // echo mapping after reset
        end
        repeat (10) @(posedge packet_data_in);
        @(negedge packet_data_in);
        rst = 1'b0;
        verify_reset_state();
        route_default_echo();
        remap_through_control();
        stall_output_randomly();
        contend_for_table();
        $display("tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
router_pkg.sv
stream_fifo.sv
metadata_builder.sv
port_table_arbiter.sv
port_table.sv
egress_stage.sv
p4_router_echo_top.sv
tb_router.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the router testbench with Verilator, run it, then look for the pass line.

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_router \
    -f sources.f --Mdir obj_dir -o tb_router_sim > build.log 2>&1 \
    && ./obj_dir/tb_router_sim > sim.log 2>&1 \
    ; grep -q "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
